//--- common/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  localparam int XLEN     = 64;
  localparam int INST_LEN = 32;
  localparam int TRAP_LEN = 16;

  // trap bus bit positions, as the mcause codes
  localparam int TRAP_INST_ADDR_MISALIGNED = 0;
  localparam int TRAP_INST_ACCESS_FAULT    = 1;
  localparam int TRAP_INST_PAGE_FAULT      = 12;  // never raised, no mmu here

  // addi x0, x0, 0
  localparam logic [INST_LEN-1:0] INST_NOP = 32'h0000_0013;

  // major opcodes seen by the static predictor
  localparam logic [6:0] OPC_JAL    = 7'b110_1111;
  localparam logic [6:0] OPC_BRANCH = 7'b110_0011;

  // fault code carried through the queue
  typedef enum logic [1:0] {
    FAULT_NONE       = 2'd0,
    FAULT_MISALIGNED = 2'd1,
    FAULT_ACCESS     = 2'd2
  } fault_e;

  // one queue entry, 98 bits
  typedef struct packed {
    logic [XLEN-1:0]     pc;
    logic [INST_LEN-1:0] inst;
    fault_e              fault;
  } fetch_entry_t;

endpackage

`default_nettype wire

//--- fetch/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
  parameter logic [fetch_pkg::XLEN-1:0] RESET_PC = 64'h8000_0000
) (
  input  logic                          clk,
  input  logic                          reset_i,
  input  logic                          redirect_valid_i,
  input  logic [fetch_pkg::XLEN-1:0]    redirect_pc_i,
  input  logic [fetch_pkg::INST_LEN-1:0] wb_dat_i,
  input  logic                          wb_ack_i,
  input  logic                          wb_err_i,
  input  logic                          q_full_i,
  output logic                          wb_cyc_o,
  output logic                          wb_stb_o,
  output logic                          wb_we_o,
  output logic [fetch_pkg::XLEN-1:0]    wb_adr_o,
  output logic                          q_push_o,
  output fetch_pkg::fetch_entry_t       q_entry_o
);

  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_BUS  = 2'd1,
    ST_HALT = 2'd2
  } state_e;

  state_e                     state_q;
  logic [fetch_pkg::XLEN-1:0] pc_q;
  logic [fetch_pkg::XLEN-1:0] adr_q;
  logic                       discard_q;  // cycle outlived a redirect

  logic                       misaligned;
  logic                       bus_done;
  logic                       start_bus;
  logic                       push_fault;
  logic                       push_bus;
  logic [6:0]                 opcode;
  logic [fetch_pkg::XLEN-1:0] imm_j;
  logic [fetch_pkg::XLEN-1:0] imm_b;
  logic [fetch_pkg::XLEN-1:0] next_pc;

  assign misaligned = (pc_q[1:0] != 2'b00);
  assign bus_done   = (state_q == ST_BUS) && (wb_ack_i || wb_err_i);

  // a redirect in the same cycle always wins over a new fetch
  assign start_bus  = (state_q == ST_IDLE) && !redirect_valid_i && !q_full_i && !misaligned;
  assign push_fault = (state_q == ST_IDLE) && !redirect_valid_i && !q_full_i && misaligned;
  assign push_bus   = bus_done && !discard_q && !redirect_valid_i;

  assign q_push_o = push_fault || push_bus;

  // read-only classic master, cyc and stb move together
  assign wb_cyc_o = (state_q == ST_BUS);
  assign wb_stb_o = (state_q == ST_BUS);
  assign wb_we_o  = 1'b0;
  assign wb_adr_o = adr_q;

  // static predecode of the returned word
  assign opcode = wb_dat_i[6:0];
  assign imm_j  = {{44{wb_dat_i[31]}}, wb_dat_i[19:12], wb_dat_i[20], wb_dat_i[30:21], 1'b0};
  assign imm_b  = {{52{wb_dat_i[31]}}, wb_dat_i[7], wb_dat_i[30:25], wb_dat_i[11:8], 1'b0};

  always_comb begin
    if (opcode == fetch_pkg::OPC_JAL) begin
      next_pc = pc_q + imm_j;  // always taken
    end else if (opcode == fetch_pkg::OPC_BRANCH && wb_dat_i[31]) begin
      next_pc = pc_q + imm_b;  // backward, assume a loop
    end else begin
      next_pc = pc_q + 64'd4;
    end
  end

  always_comb begin
    q_entry_o.pc = pc_q;
    if (push_fault) begin
      q_entry_o.inst  = fetch_pkg::INST_NOP;
      q_entry_o.fault = fetch_pkg::FAULT_MISALIGNED;
    end else if (wb_err_i) begin
      q_entry_o.inst  = fetch_pkg::INST_NOP;
      q_entry_o.fault = fetch_pkg::FAULT_ACCESS;
    end else begin
      q_entry_o.inst  = wb_dat_i;
      q_entry_o.fault = fetch_pkg::FAULT_NONE;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      pc_q <= RESET_PC;
    end else if (redirect_valid_i) begin
      pc_q <= redirect_pc_i;
    end else if (push_bus && !wb_err_i) begin
      pc_q <= next_pc;
    end
  end

  // address held for the whole cycle, even across a redirect
  always_ff @(posedge clk) begin
    if (start_bus) begin
      adr_q <= {pc_q[fetch_pkg::XLEN-1:2], 2'b00};
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q   <= ST_IDLE;
      discard_q <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (start_bus) begin
            state_q <= ST_BUS;
          end else if (push_fault) begin
            state_q <= ST_HALT;  // wait for a redirect
          end
        end
        ST_BUS: begin
          if (bus_done) begin
            discard_q <= 1'b0;
            if (push_bus && wb_err_i) begin
              state_q <= ST_HALT;
            end else begin
              state_q <= ST_IDLE;
            end
          end else if (redirect_valid_i) begin
            discard_q <= 1'b1;  // drop the word when it shows up
          end
        end
        ST_HALT: begin
          if (redirect_valid_i) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verilog/inst_queue.sv
`timescale 1ns/1ps
`default_nettype none

module inst_queue #(
  parameter int  DEPTH   = 4,
  parameter type entry_t = logic [31:0]
) (
  input  logic   clk,
  input  logic   reset_i,
  input  logic   flush_i,
  input  logic   push_i,
  input  entry_t push_data_i,
  input  logic   pop_i,
  output entry_t pop_data_o,
  output logic   full_o,
  output logic   empty_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  entry_t           mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  assign pop_data_o = mem_q[rd_ptr_q];  // head is always visible

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i || flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (do_pop)  rd_ptr_q <= ptr_inc(rd_ptr_q);
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // both or neither
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verilog/id_issue.sv
`timescale 1ns/1ps
`default_nettype none

module id_issue (
  input  logic                           clk,
  input  logic                           reset_i,
  input  logic                           flush_i,
  input  logic                           q_empty_i,
  input  fetch_pkg::fetch_entry_t        q_data_i,
  input  logic                           id_ready_i,
  output logic                           q_pop_o,
  output logic                           id_valid_o,
  output logic [fetch_pkg::XLEN-1:0]     id_pc_o,
  output logic [fetch_pkg::INST_LEN-1:0] id_inst_o,
  output logic [fetch_pkg::TRAP_LEN-1:0] id_trap_o
);

  logic                    valid_q;
  fetch_pkg::fetch_entry_t entry_q;

  // refill when empty or when decode drains us this cycle
  assign q_pop_o = !q_empty_i && (!valid_q || id_ready_i);

  always_ff @(posedge clk) begin
    if (reset_i || flush_i) begin
      valid_q <= 1'b0;
    end else if (q_pop_o) begin
      valid_q <= 1'b1;
    end else if (id_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (q_pop_o) begin
      entry_q <= q_data_i;
    end
  end

  assign id_valid_o = valid_q;
  assign id_pc_o    = entry_q.pc;
  assign id_inst_o  = (entry_q.fault == fetch_pkg::FAULT_NONE) ? entry_q.inst
                                                               : fetch_pkg::INST_NOP;

  // fault code to one-hot trap bits
  always_comb begin
    id_trap_o = '0;
    id_trap_o[fetch_pkg::TRAP_INST_ADDR_MISALIGNED] =
        (entry_q.fault == fetch_pkg::FAULT_MISALIGNED);
    id_trap_o[fetch_pkg::TRAP_INST_ACCESS_FAULT] =
        (entry_q.fault == fetch_pkg::FAULT_ACCESS);
    id_trap_o[fetch_pkg::TRAP_INST_PAGE_FAULT] = 1'b0;  // no translation
  end

endmodule

`default_nettype wire

//--- verilog/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top #(
  parameter logic [fetch_pkg::XLEN-1:0] RESET_PC    = 64'h8000_0000,
  parameter int                         QUEUE_DEPTH = 4
) (
  input  logic                           clk,
  input  logic                           reset_i,
  input  logic                           redirect_valid_i,
  input  logic [fetch_pkg::XLEN-1:0]     redirect_pc_i,
  output logic                           wb_cyc_o,
  output logic                           wb_stb_o,
  output logic                           wb_we_o,
  output logic [fetch_pkg::XLEN-1:0]     wb_adr_o,
  input  logic [fetch_pkg::INST_LEN-1:0] wb_dat_i,
  input  logic                           wb_ack_i,
  input  logic                           wb_err_i,
  output logic                           id_valid_o,
  output logic [fetch_pkg::XLEN-1:0]     id_pc_o,
  output logic [fetch_pkg::INST_LEN-1:0] id_inst_o,
  output logic [fetch_pkg::TRAP_LEN-1:0] id_trap_o,
  input  logic                           id_ready_i
);

  logic                    q_push;
  fetch_pkg::fetch_entry_t q_push_entry;
  logic                    q_full;
  logic                    q_empty;
  logic                    q_pop;
  fetch_pkg::fetch_entry_t q_head;

  fetch_unit #(
    .RESET_PC (RESET_PC)
  ) fetch_unit_i (
    .clk              (clk),
    .reset_i          (reset_i),
    .redirect_valid_i (redirect_valid_i),
    .redirect_pc_i    (redirect_pc_i),
    .wb_dat_i         (wb_dat_i),
    .wb_ack_i         (wb_ack_i),
    .wb_err_i         (wb_err_i),
    .q_full_i         (q_full),
    .wb_cyc_o         (wb_cyc_o),
    .wb_stb_o         (wb_stb_o),
    .wb_we_o          (wb_we_o),
    .wb_adr_o         (wb_adr_o),
    .q_push_o         (q_push),
    .q_entry_o        (q_push_entry)
  );

  inst_queue #(
    .DEPTH   (QUEUE_DEPTH),
    .entry_t (fetch_pkg::fetch_entry_t)
  ) inst_queue_i (
    .clk         (clk),
    .reset_i     (reset_i),
    .flush_i     (redirect_valid_i),
    .push_i      (q_push),
    .push_data_i (q_push_entry),
    .pop_i       (q_pop),
    .pop_data_o  (q_head),
    .full_o      (q_full),
    .empty_o     (q_empty)
  );

  id_issue id_issue_i (
    .clk        (clk),
    .reset_i    (reset_i),
    .flush_i    (redirect_valid_i),
    .q_empty_i  (q_empty),
    .q_data_i   (q_head),
    .id_ready_i (id_ready_i),
    .q_pop_o    (q_pop),
    .id_valid_o (id_valid_o),
    .id_pc_o    (id_pc_o),
    .id_inst_o  (id_inst_o),
    .id_trap_o  (id_trap_o)
  );

endmodule

`default_nettype wire

//--- dv/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;  // 10 ns period
  end

  initial begin
    reset_o = 1'b1;
    repeat (2) @(posedge clk_o);
    #1 reset_o = 1'b0;
  end

endmodule

`default_nettype wire

//--- dv/fetch_unit_chk.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit_chk (
  input logic                       clk,
  input logic                       reset_i,
  input logic                       wb_cyc_i,
  input logic                       wb_stb_i,
  input logic                       wb_we_i,
  input logic [fetch_pkg::XLEN-1:0] wb_adr_i,
  input logic                       wb_ack_i,
  input logic                       wb_err_i,
  input logic                       q_push_i,
  input logic [1:0]                 q_fault_i
);

  a_stb_eq_cyc: assert property (@(posedge clk) disable iff (reset_i)
    wb_stb_i == wb_cyc_i) else $error("stb differs from cyc");

  a_read_only: assert property (@(posedge clk) disable iff (reset_i)
    !wb_we_i) else $error("write enable raised");

  // address and strobe hold until the slave answers
  a_hold_cycle: assert property (@(posedge clk) disable iff (reset_i)
    wb_cyc_i && !(wb_ack_i || wb_err_i) |=> wb_cyc_i && wb_stb_i && $stable(wb_adr_i))
    else $error("bus cycle changed before ack");

  a_drop_after_ack: assert property (@(posedge clk) disable iff (reset_i)
    wb_cyc_i && (wb_ack_i || wb_err_i) |=> !wb_cyc_i) else $error("cyc held after ack");

  // misaligned fault never goes to the bus
  a_misaligned_no_bus: assert property (@(posedge clk) disable iff (reset_i)
    q_push_i && q_fault_i == fetch_pkg::FAULT_MISALIGNED |-> !wb_cyc_i)
    else $error("bus cycle during misaligned fault");

endmodule

bind fetch_unit fetch_unit_chk chk_i (
  .clk       (clk),
  .reset_i   (reset_i),
  .wb_cyc_i  (wb_cyc_o),
  .wb_stb_i  (wb_stb_o),
  .wb_we_i   (wb_we_o),
  .wb_adr_i  (wb_adr_o),
  .wb_ack_i  (wb_ack_i),
  .wb_err_i  (wb_err_i),
  .q_push_i  (q_push_o),
  .q_fault_i (q_entry_o.fault)
);

`default_nettype wire

//--- dv/fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;

  localparam logic [63:0] RESET_PC  = 64'h8000_0000;
  localparam logic [63:0] FAULT_LO  = 64'h8000_2000;  // err window
  localparam logic [63:0] FAULT_HI  = 64'h8000_20ff;
  localparam logic [31:0] NOP       = 32'h0000_0013;
  localparam int          TIMEOUT   = 2000;

  logic        clk;
  logic        reset;
  logic        redirect_valid;
  logic [63:0] redirect_pc;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [63:0] wb_adr;
  logic [31:0] wb_dat;
  logic        wb_ack;
  logic        wb_err;
  logic        id_valid;
  logic [63:0] id_pc;
  logic [31:0] id_inst;
  logic [15:0] id_trap;
  logic        id_ready;

  logic [31:0] mem [logic [63:0]];
  logic        slave_busy;
  int unsigned slave_wait;
  logic [63:0] ref_pc;
  logic        ref_halted;
  int          issued;
  logic        random_ready;
  logic        hold_valid;
  logic [63:0] hold_pc;
  logic [31:0] hold_inst;
  logic [15:0] hold_trap;

  tb_clk_gen clk_gen_i (.clk_o(clk), .reset_o(reset));

  fetch_top #(
    .RESET_PC    (RESET_PC),
    .QUEUE_DEPTH (4)
  ) dut_i (
    .clk (clk), .reset_i (reset),
    .redirect_valid_i (redirect_valid), .redirect_pc_i (redirect_pc),
    .wb_cyc_o (wb_cyc), .wb_stb_o (wb_stb), .wb_we_o (wb_we), .wb_adr_o (wb_adr),
    .wb_dat_i (wb_dat), .wb_ack_i (wb_ack), .wb_err_i (wb_err),
    .id_valid_o (id_valid), .id_pc_o (id_pc), .id_inst_o (id_inst),
    .id_trap_o (id_trap), .id_ready_i (id_ready)
  );

  // filler words are addi with address bits folded into the upper field
  function automatic logic [31:0] mem_word(input logic [63:0] addr);
    logic [24:0] fold;
    fold = addr[26:2] ^ addr[51:27] ^ {13'd0, addr[63:52]};
    if (mem.exists(addr)) return mem[addr];
    return {fold, 7'h13};
  endfunction

  function automatic logic in_fault_window(input logic [63:0] addr);
    return (addr >= FAULT_LO) && (addr <= FAULT_HI);
  endfunction

  // static prediction per RV64 J and B immediates
  function automatic logic [63:0] predict_next(input logic [63:0] pc, input logic [31:0] i);
    logic [63:0] jimm;
    logic [63:0] bimm;
    jimm = {{44{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
    bimm = {{52{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
    if (i[6:0] == 7'h6f) return pc + jimm;
    if (i[6:0] == 7'h63 && i[31]) return pc + bimm;
    return pc + 64'd4;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] exp,
                             input logic [63:0] act);
    assert (exp === act) else
      fail_run($sformatf("[ERROR] %0t %s expected %h got %h", $time, name, exp, act));
  endtask

  // wishbone slave, random ack delay of 0 to 3 cycles
  always @(posedge clk) begin
    #1;
    if (reset) begin
      wb_ack = 1'b0;
      wb_err = 1'b0;
      slave_busy = 1'b0;
    end else if (wb_ack || wb_err) begin
      wb_ack = 1'b0;
      wb_err = 1'b0;
      slave_busy = 1'b0;
    end else if (wb_cyc && wb_stb) begin
      if (!slave_busy) begin
        slave_busy = 1'b1;
        slave_wait = $urandom_range(3, 0);
      end
      if (slave_wait == 0) begin
        if (in_fault_window(wb_adr)) wb_err = 1'b1;
        else begin
          wb_ack = 1'b1;
          wb_dat = mem_word(wb_adr);
        end
      end else begin
        slave_wait = slave_wait - 1;
      end
    end
  end

  // reference model, sampled mid-cycle where all signals are settled
  always @(negedge clk) begin
    if (reset) begin
      ref_pc = RESET_PC;
      ref_halted = 1'b0;
      hold_valid = 1'b0;
    end else begin
      if (hold_valid) begin
        assert (id_valid) else fail_run("valid dropped while decode stalled");
        check_value("id_pc_o", hold_pc, id_pc);
        check_value("id_inst_o", 64'(hold_inst), 64'(id_inst));
        check_value("id_trap_o", 64'(hold_trap), 64'(id_trap));
      end
      if (id_valid && id_ready) begin
        assert (!ref_halted) else fail_run("word issued after a fault without redirect");
        check_value("id_pc_o", ref_pc, id_pc);
        if (ref_pc[1:0] != 2'b00) begin
          check_value("id_inst_o", 64'(NOP), 64'(id_inst));
          check_value("id_trap_o", 64'h1, 64'(id_trap));
          ref_halted = 1'b1;
        end else if (in_fault_window(ref_pc)) begin
          check_value("id_inst_o", 64'(NOP), 64'(id_inst));
          check_value("id_trap_o", 64'h2, 64'(id_trap));
          ref_halted = 1'b1;
        end else begin
          check_value("id_inst_o", 64'(mem_word(ref_pc)), 64'(id_inst));
          check_value("id_trap_o", 64'h0, 64'(id_trap));
          ref_pc = predict_next(ref_pc, mem_word(ref_pc));
        end
        issued = issued + 1;
      end
      hold_valid = id_valid && !id_ready && !redirect_valid;
      hold_pc = id_pc;
      hold_inst = id_inst;
      hold_trap = id_trap;
      if (redirect_valid) begin
        ref_pc = redirect_pc;
        ref_halted = 1'b0;
      end
    end
  end

  task automatic step();
    @(posedge clk);
    #1;
    if (random_ready) id_ready = $urandom_range(1, 0);
  endtask

  task automatic wait_issues(input int n, input string what);
    int target;
    int cycles;
    target = issued + n;
    cycles = 0;
    while (issued < target) begin
      step();
      cycles++;
      if (cycles > TIMEOUT) fail_run($sformatf("timeout waiting for %s", what));
    end
  endtask

  task automatic wait_bus_cycle();
    int cycles;
    cycles = 0;
    while (!wb_cyc) begin
      step();
      cycles++;
      if (cycles > TIMEOUT) fail_run("timeout waiting for a bus cycle to open");
    end
  endtask

  task automatic redirect(input logic [63:0] pc);
    redirect_valid = 1'b1;
    redirect_pc = pc;
    step();
    redirect_valid = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) step();
  endtask

  initial begin
    void'($urandom(32'h2c42_d0e2));
    redirect_valid = 1'b0;
    redirect_pc = '0;
    wb_dat = '0;
    wb_ack = 1'b0;
    wb_err = 1'b0;
    id_ready = 1'b1;
    random_ready = 1'b0;
    issued = 0;
    slave_busy = 1'b0;
    slave_wait = 0;
    mem[64'h8000_0020] = 32'h1000_006f;  // jal x0, +0x100
    mem[64'h8000_0120] = 32'h0400_0063;  // beq forward +0x40
    mem[64'h8000_0130] = 32'hfe00_08e3;  // beq backward -0x10
    wait_reset_low();
    wait_issues(8, "sequential words");
    wait_issues(12, "predicted targets");
    wait_bus_cycle();
    redirect(64'h8000_1000);  // lands on an open cycle
    wait_issues(6, "words after redirect in open cycle");
    redirect(64'h8000_1800);
    wait_issues(4, "words after idle redirect");
    redirect(64'h8000_1ff8);
    wait_issues(3, "access fault");
    idle_cycles(20);
    redirect(64'h8000_3002);
    wait_issues(1, "misaligned fault");
    idle_cycles(20);
    random_ready = 1'b1;
    redirect(RESET_PC);
    wait_issues(16, "words under back-pressure");
    random_ready = 1'b0;
    id_ready = 1'b1;
    idle_cycles(4);
    $display("No errors");
    $finish;
  end

  task automatic wait_reset_low();
    int cycles;
    cycles = 0;
    while (reset) begin
      step();
      cycles++;
      if (cycles > TIMEOUT) fail_run("timeout waiting for reset release");
    end
  endtask

endmodule

`default_nettype wire

//--- files.f
common/fetch_pkg.sv
fetch/fetch_unit.sv
verilog/inst_queue.sv
verilog/id_issue.sv
verilog/fetch_top.sv
dv/tb_clk_gen.sv
dv/fetch_unit_chk.sv
dv/fetch_tb.sv

//--- Makefile
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f files.f --top-module fetch_tb \
		-Mdir obj_dir -o fetch_tb

run: build
	./obj_dir/fetch_tb > $(LOG) 2>&1; cat $(LOG)
	grep -q "^No errors$$" $(LOG)

lint:
	verilator --lint-only --timing -Wall -f files.f --top-module fetch_tb

clean:
	rm -rf obj_dir $(LOG)
